//--- bench/irq_testdata.txt
# columns: name op addr data lines exp_word exp_id exp_irq
# hex for addr data lines exp_word, decimal for exp_id exp_irq
reset_state  lines    000000 00000000 00 00000000 0 0
en_write     write    002000 0000005A 00 00000000 0 0
en_read      read     002000 00000000 00 0000005A 0 0
unmap_plic   read     000100 00000000 00 00000000 0 0
unmap_high   read     004000 00000000 00 00000000 0 0
pend_lines   lines    000000 00000000 A4 00000000 0 0
pend_read    read     001000 00000000 A4 000000A4 0 0
prio_mid     lines    000000 00000000 58 00000000 4 1
prio_low     lines    000000 00000000 FF 00000000 2 1
ack_low      ack      000000 00000000 FF 00000000 2 0
en_clear     write    002000 00000000 FF 00000000 0 0
prio_off     lines    000000 00000000 FF 00000000 0 0
tmr_enable   write    002000 00000001 00 00000000 0 0
cmp_hi_zero  write    00300C 00000000 00 00000000 0 0
cmp_lo_small write    003008 00000040 00 00000000 0 0
tmr_wait     wait_irq 000000 00000000 00 00000000 1 1
tmr_pend     read     001000 00000000 00 00000001 0 0
mtime_first  snap     003000 00000000 00 00000000 0 0
mtime_next   read_inc 003000 00000000 00 00000000 0 0
cmp_hi_max   write    00300C FFFFFFFF 00 00000000 0 0
cmp_lo_max   write    003008 FFFFFFFF 00 00000000 0 0
tmr_clear    lines    000000 00000000 00 00000000 0 0
cmp_read     read     00300C 00000000 00 FFFFFFFF 0 0

//--- filelist.f
+incdir+design
design/irq_pkg.sv
design/plic_regs.sv
design/plic_arbiter.sv
design/mtimer.sv
design/periph_bus_mux.sv
design/irq_subsystem.sv
bench/irq_subsystem_tb.sv

//--- Bender.yml
package:
  name: irq_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/irq_pkg.sv
      - design/plic_regs.sv
      - design/plic_arbiter.sv
      - design/mtimer.sv
      - design/periph_bus_mux.sv
      - design/irq_subsystem.sv
  - target: test
    files:
      - bench/irq_subsystem_tb.sv

//--- bench/irq_subsystem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module irq_subsystem_tb
    import irq_pkg::*;
();

    localparam int WAIT_LIMIT = 200;   // cycles per wait loop.

    typedef logic [8*16-1:0] label_t;

    logic      clk;
    logic      reset;
    bus_req_t  bus_req;
    bus_word_t rdata;
    irq_vec_t  irq_ext;
    logic      iack;
    logic      irq;
    irq_id_t   id;
    irq_vec_t  iack_vec;

    int        err_count;
    int        test_count;
    int        fail_count;
    logic      test_bad;
    bus_word_t last_word;              // previous snapshot of a counter.

    irq_subsystem UUT (
        .clk       (clk),
        .reset     (reset),
        .bus_req_i (bus_req),
        .rdata_o   (rdata),
        .irq_ext_i (irq_ext),
        .iack_i    (iack),
        .irq_o     (irq),
        .id_o      (id),
        .iack_o    (iack_vec)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_word(input label_t name, input bus_word_t exp, input bus_word_t act);
        if (act !== exp) begin
            $display("Fail %0s: expected %h, actual %h", name, exp, act);
            err_count++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_id(input label_t name, input irq_id_t exp, input irq_id_t act);
        if (act !== exp) begin
            $display("Fail %0s: expected id %0d, actual id %0d", name, exp, act);
            err_count++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_bit(input label_t name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %0s: expected %b, actual %b", name, exp, act);
            err_count++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_vec(input label_t name, input irq_vec_t exp, input irq_vec_t act);
        if (act !== exp) begin
            $display("Fail %0s: expected %b, actual %b", name, exp, act);
            err_count++;
            test_bad = 1'b1;
        end
    endtask

    // drives one strobe cycle and returns on the falling edge after it.
    task automatic bus_access(input logic write, input bus_addr_t addr, input bus_word_t data);
        bus_req.en    = 1'b1;
        bus_req.we    = write ? byte_en_t'('1) : byte_en_t'('0);
        bus_req.addr  = addr;
        bus_req.wdata = data;
        @(posedge clk);
        @(negedge clk);
        bus_req = '0;   // read word is valid in this cycle.
    endtask

    task automatic run_test(input label_t name, input label_t op, input bus_addr_t addr,
                            input bus_word_t data, input irq_vec_t lines,
                            input bus_word_t exp_word, input irq_id_t exp_id,
                            input logic exp_irq);
        irq_vec_t exp_ack;
        int       cycles;

        // acknowledge goes one-hot to the named source.
        exp_ack = (exp_id == 0) ? irq_vec_t'(0) : irq_vec_t'(1) << (exp_id - 1);
        irq_ext = lines;
        case (op)
            "write": bus_access(1'b1, addr, data);
            "read": begin
                bus_access(1'b0, addr, '0);
                check_word(name, exp_word, rdata);
            end
            "snap": begin
                bus_access(1'b0, addr, '0);
                last_word = rdata;
            end
            "read_inc": begin
                bus_access(1'b0, addr, '0);
                check_bit(name, 1'b1, rdata > last_word);
                last_word = rdata;
            end
            "lines": begin
                repeat (2) begin   // pending lags the lines by one cycle.
                    @(posedge clk);
                    @(negedge clk);
                end
                check_id(name, exp_id, id);
                check_bit(name, exp_irq, irq);
            end
            "ack": begin
                iack = 1'b1;
                @(posedge clk);
                @(negedge clk);
                check_id(name, exp_id, id);
                check_bit(name, exp_irq, irq);
                check_vec(name, exp_ack, iack_vec);
                iack = 1'b0;
            end
            "wait_irq": begin
                cycles = 0;
                while (!irq && cycles < WAIT_LIMIT) begin
                    @(posedge clk);
                    @(negedge clk);
                    cycles++;
                end
                if (!irq) begin
                    $display("%0s: interrupt request never rose within %0d cycles",
                             name, WAIT_LIMIT);
                    err_count++;
                    test_bad = 1'b1;
                end else begin
                    check_id(name, exp_id, id);
                end
            end
            default: begin
                $display("%0s: unknown operation %0s in the test data", name, op);
                err_count++;
                test_bad = 1'b1;
            end
        endcase
    endtask

    initial begin
        int               fd;
        int               n;
        int               exp_id;
        int               exp_irq;
        logic [8*120-1:0] text;
        label_t           name;
        label_t           op;
        bus_addr_t        addr;
        bus_word_t        data;
        irq_vec_t         lines;
        bus_word_t        exp_word;

        void'($urandom(92));
        err_count  = 0;
        test_count = 0;
        fail_count = 0;
        test_bad   = 1'b0;
        last_word  = '0;
        reset      = 1'b1;
        bus_req    = '0;
        irq_ext    = '0;
        iack       = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        fd = $fopen("bench/irq_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/irq_testdata.txt");
            err_count++;
        end else begin
            while ($fgets(text, fd) != 0) begin
                n = $sscanf(text, "%s %s %h %h %h %h %d %d", name, op, addr, data,
                            lines, exp_word, exp_id, exp_irq);
                if (n == 8 && name != "#") begin   // skips comments and blanks.
                    test_bad = 1'b0;
                    run_test(name, op, addr, data, lines, exp_word,
                             irq_id_t'(exp_id), exp_irq[0]);
                    test_count++;
                    if (test_bad) begin
                        fail_count++;
                        $display("test %0s failed", name);
                    end else begin
                        $display("test %0s ok", name);
                    end
                    repeat ($urandom % 4) @(negedge clk);
                end
                text = '0;
            end
            $fclose(fd);
        end

        $display("tests %0d, failed %0d, check errors %0d", test_count, fail_count, err_count);
        if (err_count == 0 && test_count > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/irq_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

`include "irq_cfg.svh"

module irq_subsystem
    import irq_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  bus_req_t  bus_req_i,
    output bus_word_t rdata_o,
    input  irq_vec_t  irq_ext_i,
    input  logic      iack_i,
    output logic      irq_o,
    output irq_id_t   id_o,
    output irq_vec_t  iack_o
);

    bus_req_t  plic_req;
    bus_req_t  tmr_req;
    bus_word_t plic_rdata;
    bus_word_t tmr_rdata;
    logic      tmr_irq;
    irq_vec_t  src;
    irq_vec_t  active;

    periph_bus_mux u_bus_mux (
        .clk          (clk),
        .reset        (reset),
        .req_i        (bus_req_i),
        .plic_req_o   (plic_req),
        .tmr_req_o    (tmr_req),
        .plic_rdata_i (plic_rdata),
        .tmr_rdata_i  (tmr_rdata),
        .rdata_o      (rdata_o)
    );

    // timer takes its slot, external bit there is ignored.
    always_comb begin
        src                 = irq_ext_i;
        src[`IRQ_TIMER_SRC] = tmr_irq;
    end

    plic_regs u_plic_regs (
        .clk      (clk),
        .reset    (reset),
        .req_i    (plic_req),
        .src_i    (src),
        .rdata_o  (plic_rdata),
        .active_o (active)
    );

    plic_arbiter u_plic_arbiter (
        .active_i (active),
        .iack_i   (iack_i),
        .irq_o    (irq_o),
        .id_o     (id_o),
        .iack_o   (iack_o)
    );

    mtimer u_mtimer (
        .clk     (clk),
        .reset   (reset),
        .req_i   (tmr_req),
        .rdata_o (tmr_rdata),
        .irq_o   (tmr_irq)
    );

endmodule

`default_nettype wire

//--- design/periph_bus_mux.sv
`timescale 1ns/100ps
`default_nettype none

`include "irq_cfg.svh"

module periph_bus_mux
    import irq_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  bus_req_t  req_i,
    output bus_req_t  plic_req_o,
    output bus_req_t  tmr_req_o,
    input  bus_word_t plic_rdata_i,
    input  bus_word_t tmr_rdata_i,
    output bus_word_t rdata_o
);

    logic plic_sel;
    logic tmr_sel;
    logic rd;
    logic plic_rd_q;    // read hit the controller last cycle.
    logic tmr_rd_q;

    assign plic_sel = (req_i.addr < `MTIME_LO_ADDR);
    assign tmr_sel  = (req_i.addr >= `MTIME_LO_ADDR) && (req_i.addr <= `MTIMECMP_HI_ADDR);
    assign rd       = req_i.en && (req_i.we == '0);

    // same request, strobe only for the block in range.
    always_comb begin
        plic_req_o    = req_i;
        plic_req_o.en = req_i.en & plic_sel;
        tmr_req_o     = req_i;
        tmr_req_o.en  = req_i.en & tmr_sel;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            plic_rd_q <= 1'b0;
            tmr_rd_q  <= 1'b0;
        end else begin
            plic_rd_q <= rd & plic_sel;
            tmr_rd_q  <= rd & tmr_sel;
        end
    end

    // unmapped or no read gives zero.
    assign rdata_o = plic_rd_q ? plic_rdata_i :
                     tmr_rd_q  ? tmr_rdata_i  : '0;

endmodule

`default_nettype wire

//--- design/mtimer.sv
`timescale 1ns/100ps
`default_nettype none

`include "irq_cfg.svh"

module mtimer
    import irq_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  bus_req_t  req_i,
    output bus_word_t rdata_o,
    output logic      irq_o
);

    timer_t mtime;
    timer_t mtimecmp;
    logic   wr;
    logic   rd;

    assign wr = req_i.en && (req_i.we != '0);
    assign rd = req_i.en && (req_i.we == '0);

    // free running count, a written half wins over the increment.
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime    <= '0;
            mtimecmp <= '1;   // no interrupt until programmed.
        end else begin
            mtime <= mtime + 1'b1;
            if (wr) begin
                case (req_i.addr)
                    `MTIME_LO_ADDR:    mtime    <= {mtime[63:32], req_i.wdata};
                    `MTIME_HI_ADDR:    mtime    <= {req_i.wdata, mtime[31:0]};
                    `MTIMECMP_LO_ADDR: mtimecmp <= {mtimecmp[63:32], req_i.wdata};
                    `MTIMECMP_HI_ADDR: mtimecmp <= {req_i.wdata, mtimecmp[31:0]};
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_o <= '0;
        end else if (rd) begin
            case (req_i.addr)
                `MTIME_LO_ADDR:    rdata_o <= mtime[31:0];
                `MTIME_HI_ADDR:    rdata_o <= mtime[63:32];
                `MTIMECMP_LO_ADDR: rdata_o <= mtimecmp[31:0];
                `MTIMECMP_HI_ADDR: rdata_o <= mtimecmp[63:32];
                default:           rdata_o <= '0;
            endcase
        end
    end

    // one cycle behind the compare.
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= (mtime >= mtimecmp);
        end
    end

endmodule

`default_nettype wire

//--- design/plic_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "irq_cfg.svh"

module plic_arbiter
    import irq_pkg::*;
(
    input  irq_vec_t active_i,
    input  logic     iack_i,
    output logic     irq_o,
    output irq_id_t  id_o,
    output irq_vec_t iack_o
);

    // scan from the top, so the lowest active id is left.
    always_comb begin
        id_o = '0;
        for (int i = `IRQ_COUNT; i >= 1; i--) begin
            if (active_i[i]) begin
                id_o = irq_id_t'(i);
            end
        end
    end

    // core acknowledge hides the request at once.
    assign irq_o = (|active_i) & ~iack_i;

    // acknowledge goes back to the granted source only.
    always_comb begin
        iack_o = '0;
        for (int i = 1; i <= `IRQ_COUNT; i++) begin
            iack_o[i] = iack_i && (id_o == irq_id_t'(i));
        end
    end

endmodule

`default_nettype wire

//--- design/plic_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "irq_cfg.svh"

module plic_regs
    import irq_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  bus_req_t  req_i,
    input  irq_vec_t  src_i,
    output bus_word_t rdata_o,
    output irq_vec_t  active_o
);

    irq_vec_t  pending;
    bus_word_t enable;
    logic      wr;
    logic      rd;

    assign wr = req_i.en && (req_i.we != '0);   // any byte lane writes the word.
    assign rd = req_i.en && (req_i.we == '0);

    // level sources, sampled every cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= src_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= '0;
        end else if (wr && (req_i.addr == `PLIC_ENABLE_ADDR)) begin
            enable <= req_i.wdata;
        end
    end

    // source 1 sits in word bit 0.
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_o <= '0;
        end else if (rd) begin
            case (req_i.addr)
                `PLIC_PENDING_ADDR: rdata_o <= bus_word_t'(pending);
                `PLIC_ENABLE_ADDR:  rdata_o <= enable;
                default:            rdata_o <= '0;
            endcase
        end
    end

    // low enable bits steer the sources.
    assign active_o = pending & enable[`IRQ_COUNT-1:0];

endmodule

`default_nettype wire

//--- design/irq_pkg.sv
`default_nettype none

`include "irq_cfg.svh"

package irq_pkg;

    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;   // byte address.
    typedef logic [`BUS_DATA_W-1:0] bus_word_t;
    typedef logic [`BUS_BE_W-1:0]   byte_en_t;

    // bit i is source i, no source 0.
    typedef logic [`IRQ_COUNT:1] irq_vec_t;

    // zero means no interrupt.
    typedef logic [$clog2(`IRQ_COUNT):0] irq_id_t;

    typedef logic [`TIMER_W-1:0] timer_t;

    // one bus request, en is a single cycle strobe.
    typedef struct packed {
        logic      en;
        byte_en_t  we;      // nonzero makes a write.
        bus_addr_t addr;
        bus_word_t wdata;
    } bus_req_t;

endpackage

`default_nettype wire

//--- design/irq_cfg.svh
`ifndef IRQ_CFG_SVH
`define IRQ_CFG_SVH

// number of interrupt sources, numbered from 1.
`define IRQ_COUNT           8
`define IRQ_TIMER_SRC       1       // machine timer source.

// bus and timer widths.
`define BUS_ADDR_W          24
`define BUS_DATA_W          32
`define BUS_BE_W            4
`define TIMER_W             64

// interrupt controller registers.
`define PLIC_PENDING_ADDR   24'h001000
`define PLIC_ENABLE_ADDR    24'h002000

// machine timer registers, one word per half.
`define MTIME_LO_ADDR       24'h003000
`define MTIME_HI_ADDR       24'h003004
`define MTIMECMP_LO_ADDR    24'h003008
`define MTIMECMP_HI_ADDR    24'h00300C

`endif
